// File: source/rvIsaPkg.sv
// ISA-level widths and encodings for the RV32I datapath, imported by every RTL module
`default_nettype none

package rvIsaPkg;

    // data and address width
    localparam int unsigned XLEN = 32;
    // register index width from the instruction fields
    localparam int unsigned REG_ADDR_W = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // sequential fetch increment
    localparam word_t PC_STEP = 32'd4;

    // encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b1000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluSra  = 4'b1101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111
    } aluOp_t;

    // B-type funct3
    typedef enum logic [2:0] {
        brEq  = 3'b000,
        brNe  = 3'b001,
        brLt  = 3'b100,
        brGe  = 3'b101,
        brLtu = 3'b110,
        brGeu = 3'b111
    } branchCond_t;

    // immediate layout of the instruction
    // immIl covers loads and JALR, immI the OP-IMM group with shift forms
    typedef enum logic [2:0] {
        immIl = 3'd0,
        immI  = 3'd1,
        immS  = 3'd2,
        immB  = 3'd3,
        immU  = 3'd4,
        immJ  = 3'd5
    } immType_t;

endpackage

`default_nettype wire

// File: source/dpCtrlPkg.sv
// Datapath control word that the external decoder presents to the core each cycle
`default_nettype none

package dpCtrlPkg;

    import rvIsaPkg::*;

    // register writeback source
    typedef enum logic [1:0] {
        wbAlu   = 2'd0,
        wbMem   = 2'd1,
        wbImm   = 2'd2,
        wbPcRel = 2'd3
    } wbSel_t;

    typedef struct packed {
        logic        regWrite;
        aluOp_t      aluOp;
        branchCond_t branchCond;
        immType_t    immType;
        // second ALU operand from immediate instead of rs2
        logic        aluSrcImm;
        wbSel_t      wbSel;
        // B-type
        logic        branch;
        // JAL and JALR, also picks pc+4 as link value
        logic        jump;
        // JALR only, target from ALU
        logic        jumpReg;
    } dpControl_t;

endpackage

`default_nettype wire

// File: source/pcControl.sv
// Program counter with next-PC selection and the PC-relative sum used for AUIPC and links
`default_nettype none
`timescale 1ns/10ps

module pcControl
    import rvIsaPkg::*, dpCtrlPkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  dpControl_t      ctrl,
    input  word_t           immExt,
    input  word_t           aluResult,
    input  wire logic       branchTaken,
    output word_t           pc,
    output word_t           pcRel
);

    word_t pcPlusStep;
    word_t pcPlusImm;
    word_t pcNext;

    assign pcPlusStep = pc + PC_STEP;
    assign pcPlusImm  = pc + immExt;

    // JALR wins, then taken branch or JAL, else fall through
    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = aluResult;
        end else if (ctrl.jump || (ctrl.branch && branchTaken)) begin
            pcNext = pcPlusImm;
        end else begin
            pcNext = pcPlusStep;
        end
    end

    // link address for jumps, AUIPC sum otherwise
    assign pcRel = ctrl.jump ? pcPlusStep : pcPlusImm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    // decoder must never raise jumpReg alone
    assert property (@(posedge clk) disable iff (reset) ctrl.jumpReg |-> ctrl.jump);

    // pc only moves at the edge, to the value selected in the previous cycle
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> pc == $past(pcNext));

endmodule

`default_nettype wire

// File: source/registerFile.sv
// Integer register file with two combinational reads and one clocked write port
`default_nettype none
`timescale 1ns/10ps

module registerFile
    import rvIsaPkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic writeEnable,
    input  regAddr_t  readAddr1,
    input  regAddr_t  readAddr2,
    input  regAddr_t  writeAddr,
    input  word_t     writeData,
    output word_t     readData1,
    output word_t     readData2
);

    // 16 entries drop the top index bit (RV32E)
    localparam int IDX_W = $clog2(NUM_REGS);

    logic [IDX_W-1:0] readIdx1;
    logic [IDX_W-1:0] readIdx2;
    logic [IDX_W-1:0] writeIdx;

    word_t regs [NUM_REGS];

    assign readIdx1 = readAddr1[IDX_W-1:0];
    assign readIdx2 = readAddr2[IDX_W-1:0];
    assign writeIdx = writeAddr[IDX_W-1:0];

    // entry 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;
        end
    end

    // plain array reads, no bypass from the write port
    assign readData1 = regs[readIdx1];
    assign readData2 = regs[readIdx2];

    // x0 holds zero across any history of writes
    assert property (@(posedge clk) disable iff (reset)
        ((readIdx1 == '0) |-> (readData1 == '0)) and
        ((readIdx2 == '0) |-> (readData2 == '0)));

endmodule

`default_nettype wire

// File: source/alu.sv
// Integer ALU with operand select and the branch comparator for conditional branches
`default_nettype none
`timescale 1ns/10ps

module alu
    import rvIsaPkg::*;
(
    input  word_t       rs1Value,
    input  word_t       rs2Value,
    input  word_t       immExt,
    input  wire logic   aluSrcImm,
    input  aluOp_t      aluOp,
    input  branchCond_t branchCond,
    output word_t       result,
    output logic        branchTaken
);

    word_t      operandB;
    logic [4:0] shamt;

    // I-type and stores use the immediate
    assign operandB = aluSrcImm ? immExt : rs2Value;
    // RV32 shifts look at five bits only
    assign shamt    = operandB[4:0];

    always_comb begin
        case (aluOp)
            aluAdd: begin
                result = rs1Value + operandB;
            end
            aluSub: begin
                result = rs1Value - operandB;
            end
            aluSll: begin
                result = rs1Value << shamt;
            end
            aluSlt: begin
                result = ($signed(rs1Value) < $signed(operandB)) ? word_t'(1) : '0;
            end
            aluSltu: begin
                result = (rs1Value < operandB) ? word_t'(1) : '0;
            end
            aluXor: begin
                result = rs1Value ^ operandB;
            end
            aluSrl: begin
                result = rs1Value >> shamt;
            end
            // arithmetic shift keeps the sign bit
            aluSra: begin
                result = word_t'($signed(rs1Value) >>> shamt);
            end
            aluOr: begin
                result = rs1Value | operandB;
            end
            aluAnd: begin
                result = rs1Value & operandB;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // compares the two registers, whatever the operand select says
    always_comb begin
        case (branchCond)
            brEq:    branchTaken = (rs1Value == rs2Value);
            brNe:    branchTaken = (rs1Value != rs2Value);
            brLt:    branchTaken = ($signed(rs1Value) < $signed(rs2Value));
            brGe:    branchTaken = ($signed(rs1Value) >= $signed(rs2Value));
            brLtu:   branchTaken = (rs1Value < rs2Value);
            brGeu:   branchTaken = (rs1Value >= rs2Value);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/immExtend.sv
// Immediate extraction and sign extension from the upper instruction bits per format
`default_nettype none
`timescale 1ns/10ps

module immExtend
    import rvIsaPkg::*;
(
    input  wire logic [31:7] instrBits,
    input  immType_t         immType,
    output word_t            immExt
);

    logic [2:0] funct3;
    logic       signBit;
    logic       isShift;

    assign funct3  = instrBits[14:12];
    assign signBit = instrBits[31];
    // SLLI, SRLI and SRAI carry a shift amount, not a 12-bit value
    assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        case (immType)
            // loads and JALR
            immIl: begin
                immExt = {{21{signBit}}, instrBits[30:20]};
            end
            immI: begin
                if (isShift) begin
                    // funct7 bits must not leak into the amount
                    immExt = {27'b0, instrBits[24:20]};
                end else begin
                    immExt = {{21{signBit}}, instrBits[30:20]};
                end
            end
            // split across rd and funct7 slots
            immS: begin
                immExt = {{21{signBit}}, instrBits[30:25], instrBits[11:7]};
            end
            immB: begin
                immExt = {{20{signBit}}, instrBits[7], instrBits[30:25],
                          instrBits[11:8], 1'b0};
            end
            // LUI and AUIPC, low twelve bits zero
            immU: begin
                immExt = {instrBits[31:12], 12'b0};
            end
            immJ: begin
                immExt = {{12{signBit}}, instrBits[19:12], instrBits[20],
                          instrBits[30:21], 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/riscvDataPath.sv
// Single-cycle RV32I datapath top, driven by an external decoder and combinational memories
`default_nettype none
`timescale 1ns/10ps

module riscvDataPath
    import rvIsaPkg::*, dpCtrlPkg::*;
#(
    parameter word_t RESET_PC = '0,
    parameter int    NUM_REGS = 32
) (
    input  wire logic clk,
    input  wire logic reset,
    input  word_t     machineCode,
    input  dpControl_t ctrl,
    input  word_t     dataMemRData,
    output word_t     instrMemRAddr,
    output word_t     dataMemRAddr,
    output word_t     dataMemWData
);

    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;

    word_t rs1Value;
    word_t rs2Value;
    word_t immExt;
    word_t aluResult;
    word_t pcRel;
    word_t writeBack;
    logic  branchTaken;

    // fixed RV32I field positions
    assign rs1 = machineCode[19:15];
    assign rs2 = machineCode[24:20];
    assign rd  = machineCode[11:7];

    pcControl #(
        .RESET_PC(RESET_PC)
    ) uPcControl (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .immExt     (immExt),
        .aluResult  (aluResult),
        .branchTaken(branchTaken),
        .pc         (instrMemRAddr),
        .pcRel      (pcRel)
    );

    registerFile #(
        .NUM_REGS(NUM_REGS)
    ) uRegisterFile (
        .clk        (clk),
        .reset      (reset),
        .writeEnable(ctrl.regWrite),
        .readAddr1  (rs1),
        .readAddr2  (rs2),
        .writeAddr  (rd),
        .writeData  (writeBack),
        .readData1  (rs1Value),
        .readData2  (rs2Value)
    );

    alu uAlu (
        .rs1Value   (rs1Value),
        .rs2Value   (rs2Value),
        .immExt     (immExt),
        .aluSrcImm  (ctrl.aluSrcImm),
        .aluOp      (ctrl.aluOp),
        .branchCond (ctrl.branchCond),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    // opcode bits are not needed by the extender
    immExtend uImmExtend (
        .instrBits(machineCode[31:7]),
        .immType  (ctrl.immType),
        .immExt   (immExt)
    );

    // word-only loads, memory data goes in unchanged
    always_comb begin
        case (ctrl.wbSel)
            wbAlu:   writeBack = aluResult;
            wbMem:   writeBack = dataMemRData;
            wbImm:   writeBack = immExt;
            wbPcRel: writeBack = pcRel;
            default: writeBack = aluResult;
        endcase
    end

    // effective address for loads and stores, rs2 is the store word
    assign dataMemRAddr = aluResult;
    assign dataMemWData = rs2Value;

    // decoder hands the ALU only defined operations
    assert property (@(posedge clk) disable iff (reset)
        ctrl.aluOp inside {aluAdd, aluSub, aluSll, aluSlt, aluSltu,
                           aluXor, aluSrl, aluSra, aluOr, aluAnd});

endmodule

`default_nettype wire

// File: tb/tbRiscvDataPath.sv
// Self-checking testbench for the RV32I datapath, acting as decoder and both memories
`default_nettype none
`timescale 1ns/10ps

module tbRiscvDataPath
    import rvIsaPkg::*, dpCtrlPkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PAIRS    = 60;
    // seven instructions per random pair, directed sections stay below 200
    localparam int TOTAL_INSTR  = 32 + 10 * NUM_PAIRS * 7 + 200;

    // expected outputs plus the state change of one instruction
    typedef struct packed {
        word_t    pc;
        word_t    dataAddr;
        word_t    wData;
        word_t    nextPc;
        logic     wrEn;
        regAddr_t wrIdx;
        word_t    wrVal;
    } expect_t;

    logic       clk;
    logic       reset;
    word_t      machineCode;
    dpControl_t ctrl;
    word_t      dataMemRData;
    word_t      instrMemRAddr;
    word_t      dataMemRAddr;
    word_t      dataMemWData;

    word_t   modelRegs [32];
    word_t   modelPc;
    expect_t expected;
    string   testName;
    logic    checkValid;
    int      errorCount;
    int      checkCount;
    integer  seed;

    aluOp_t opList [10] = '{aluAdd, aluSub, aluSll, aluSlt, aluSltu,
                            aluXor, aluSrl, aluSra, aluOr, aluAnd};
    branchCond_t condList [6] = '{brEq, brNe, brLt, brGe, brLtu, brGeu};
    // operand pairs, each condition sees both outcomes
    regAddr_t firstReg [3]  = '{5'd5, 5'd6, 5'd6};
    regAddr_t secondReg [3] = '{5'd6, 5'd5, 5'd7};

    riscvDataPath UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // R form goes through here too, {funct7, rs2} in the immediate slot
    function automatic word_t encodeI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                      regAddr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encodeS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t encodeB(logic [12:0] imm, regAddr_t rs2, regAddr_t rs1,
                                      logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t encodeJ(logic [20:0] imm, regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic dpControl_t makeCtrl(logic wr, aluOp_t op, immType_t it, logic srcImm,
                                            wbSel_t wb);
        dpControl_t c;
        c = '0;
        c.regWrite  = wr;
        c.aluOp     = op;
        c.immType   = it;
        c.aluSrcImm = srcImm;
        c.wbSel     = wb;
        return c;
    endfunction

    // one instruction of the architectural model, straight from the RV32I rules
    function automatic expect_t refModel(word_t pcNow, word_t instr, dpControl_t c,
                                         word_t rdata);
        expect_t e;
        word_t   a;
        word_t   r2;
        word_t   b;
        word_t   iImm;
        word_t   imm;
        word_t   res;
        logic    lessS;
        logic    taken;
        a    = modelRegs[instr[19:15]];
        r2   = modelRegs[instr[24:20]];
        iImm = {{20{instr[31]}}, instr[31:20]};
        case (c.immType)
            immIl:   imm = iImm;
            // funct3 001 and 101 are the shift forms
            immI:    imm = (instr[13:12] == 2'b01) ? {27'd0, instr[24:20]} : iImm;
            immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU:    imm = {instr[31:12], 12'd0};
            immJ:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
        b = c.aluSrcImm ? imm : r2;
        // signed order by sign bits first, magnitude when they agree
        lessS = (a[31] != b[31]) ? a[31] : (a < b);
        case (c.aluOp)
            aluAdd:  res = a + b;
            aluSub:  res = a - b;
            aluSll:  res = a << b[4:0];
            aluSlt:  res = {31'd0, lessS};
            aluSltu: res = {31'd0, a < b};
            aluXor:  res = a ^ b;
            aluSrl:  res = a >> b[4:0];
            // logical shift with the vacated top bits filled by the sign
            aluSra:  res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            aluOr:   res = a | b;
            aluAnd:  res = a & b;
            default: res = '0;
        endcase
        // branches always compare the two registers
        lessS = (a[31] != r2[31]) ? a[31] : (a < r2);
        case (c.branchCond)
            brEq:    taken = (a == r2);
            brNe:    taken = (a != r2);
            brLt:    taken = lessS;
            brGe:    taken = !lessS;
            brLtu:   taken = (a < r2);
            brGeu:   taken = (a >= r2);
            default: taken = 1'b0;
        endcase
        e.pc       = pcNow;
        e.dataAddr = res;
        e.wData    = r2;
        e.nextPc   = c.jumpReg ? res :
                     ((c.jump || (c.branch && taken)) ? pcNow + imm : pcNow + 32'd4);
        case (c.wbSel)
            wbAlu:   e.wrVal = res;
            wbMem:   e.wrVal = rdata;
            wbImm:   e.wrVal = imm;
            default: e.wrVal = c.jump ? pcNow + 32'd4 : pcNow + imm;
        endcase
        e.wrEn  = c.regWrite && (instr[11:7] != 5'd0);
        e.wrIdx = instr[11:7];
        return e;
    endfunction

    task automatic compareWord(input string what, input word_t exp, input word_t act);
        checkCount++;
        assert (act === exp) else begin
            errorCount++;
            $display("[FAIL] %s %s expected %h actual %h", testName, what, exp, act);
        end
    endtask

    // sampled 1 ns ahead of the rising edge
    initial begin
        forever begin
            @(negedge clk);
            #(CLK_PERIOD / 2 - 1);
            if (checkValid) begin
                compareWord("instrMemRAddr", expected.pc, instrMemRAddr);
                compareWord("dataMemRAddr", expected.dataAddr, dataMemRAddr);
                compareWord("dataMemWData", expected.wData, dataMemWData);
            end
        end
    end

    initial begin
        #((TOTAL_INSTR + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired before the instruction sequence completed");
        $display("checks %0d errors %0d", checkCount, errorCount + 1);
        $display("=== FAIL ===");
        $finish;
    end

    // presents one instruction at the falling edge, model steps along
    task automatic runInstr(input string name, input word_t instr, input dpControl_t c,
                            input word_t rdata);
        machineCode  = instr;
        ctrl         = c;
        dataMemRData = rdata;
        expected     = refModel(modelPc, instr, c, rdata);
        testName     = name;
        checkValid   = 1'b1;
        modelPc      = expected.nextPc;
        if (expected.wrEn) begin
            modelRegs[expected.wrIdx] = expected.wrVal;
        end
        @(negedge clk);
    endtask

    // LUI then ADDI, upper part rounded for the sign-extended low part
    task automatic loadReg(input regAddr_t rd, input word_t value);
        logic [19:0] upper;
        upper = value[31:12] + {19'd0, value[11]};
        runInstr("load lui", {upper, rd, 7'h37}, makeCtrl(1'b1, aluAdd, immU, 1'b0, wbImm), '0);
        runInstr("load addi", encodeI(value[11:0], rd, 3'b000, rd, 7'h13),
                 makeCtrl(1'b1, aluAdd, immI, 1'b1, wbAlu), '0);
    endtask

    // store form to x0 base, register appears on the write data
    task automatic showReg(input string name, input regAddr_t rs2);
        runInstr(name, encodeS(12'd0, rs2, 5'd0), makeCtrl(1'b0, aluAdd, immS, 1'b1, wbAlu), '0);
    endtask

    initial begin : mainSequence
        word_t       valA;
        word_t       rnd;
        logic [11:0] imm12;
        aluOp_t      op;
        branchCond_t cond;
        dpControl_t  c;
        seed         = 75;
        errorCount   = 0;
        checkCount   = 0;
        checkValid   = 1'b0;
        testName     = "reset";
        reset        = 1'b1;
        machineCode  = '0;
        ctrl         = '0;
        dataMemRData = '0;
        modelPc      = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // pc at reset value, every register reads zero
        for (int r = 0; r < 32; r++) begin
            runInstr("reset read", encodeI(12'd0, regAddr_t'(r), 3'b000, 5'd0, 7'h13),
                     makeCtrl(1'b1, aluAdd, immI, 1'b1, wbAlu), '0);
        end
        // random operands, register form into x3 and immediate form into x4
        for (int k = 0; k < 10; k++) begin
            op = opList[k];
            for (int n = 0; n < NUM_PAIRS; n++) begin
                valA = $random(seed);
                loadReg(5'd1, valA);
                valA = $random(seed);
                loadReg(5'd2, valA);
                runInstr($sformatf("%s reg", op.name()),
                         encodeI({1'b0, op[3], 5'd0, 5'd2}, 5'd1, op[2:0], 5'd3, 7'h33),
                         makeCtrl(1'b1, op, immI, 1'b0, wbAlu), '0);
                rnd = $random(seed);
                // no SUBI in the ISA
                if (op != aluSub) begin
                    imm12 = (op[1:0] == 2'b01) ? {1'b0, op[3], 5'd0, rnd[4:0]} : rnd[11:0];
                    runInstr($sformatf("%s imm", op.name()),
                             encodeI(imm12, 5'd1, op[2:0], 5'd4, 7'h13),
                             makeCtrl(1'b1, op, immI, 1'b1, wbAlu), '0);
                end
                // written results come back as address and store data
                runInstr("alu readback", encodeS(12'd0, 5'd3, 5'd4),
                         makeCtrl(1'b0, aluAdd, immS, 1'b1, wbAlu), '0);
            end
        end
        // x0 stays zero after writes
        runInstr("x0 addi", encodeI(12'h5a5, 5'd1, 3'b000, 5'd0, 7'h13),
                 makeCtrl(1'b1, aluAdd, immI, 1'b1, wbAlu), '0);
        runInstr("x0 lui", {20'hfffff, 5'd0, 7'h37}, makeCtrl(1'b1, aluAdd, immU, 1'b0, wbImm), '0);
        showReg("x0 readback", 5'd0);
        // -3, 7, 7 give taken and not taken for all six conditions
        loadReg(5'd5, 32'hffff_fffd);
        loadReg(5'd6, 32'd7);
        loadReg(5'd7, 32'd7);
        for (int k = 0; k < 6; k++) begin
            cond = condList[k];
            c = makeCtrl(1'b0, aluSub, immB, 1'b0, wbAlu);
            c.branchCond = cond;
            c.branch = 1'b1;
            for (int p = 0; p < 3; p++) begin
                rnd = $random(seed);
                runInstr($sformatf("%s branch", cond.name()),
                         encodeB({rnd[12:1], 1'b0}, secondReg[p], firstReg[p], cond), c, '0);
            end
        end
        // jal links pc+4
        rnd = $random(seed);
        c = makeCtrl(1'b1, aluAdd, immJ, 1'b0, wbPcRel);
        c.jump = 1'b1;
        runInstr("jal", encodeJ({rnd[20:1], 1'b0}, 5'd8), c, '0);
        showReg("jal link", 5'd8);
        // even base and offset for jalr
        rnd = $random(seed);
        loadReg(5'd10, {rnd[31:1], 1'b0});
        rnd = $random(seed);
        c = makeCtrl(1'b1, aluAdd, immIl, 1'b1, wbPcRel);
        c.jump = 1'b1;
        c.jumpReg = 1'b1;
        runInstr("jalr", encodeI({rnd[11:1], 1'b0}, 5'd10, 3'b000, 5'd9, 7'h67), c, '0);
        showReg("jalr link", 5'd9);
        rnd = $random(seed);
        runInstr("lui", {rnd[31:12], 5'd11, 7'h37}, makeCtrl(1'b1, aluAdd, immU, 1'b0, wbImm), '0);
        showReg("lui value", 5'd11);
        rnd = $random(seed);
        runInstr("auipc", {rnd[31:12], 5'd12, 7'h17},
                 makeCtrl(1'b1, aluAdd, immU, 1'b0, wbPcRel), '0);
        showReg("auipc value", 5'd12);
        // word load straight from the read data bus
        rnd = $random(seed);
        valA = $random(seed);
        runInstr("load word", encodeI(rnd[11:0], 5'd0, 3'b010, 5'd13, 7'h03),
                 makeCtrl(1'b1, aluAdd, immIl, 1'b1, wbMem), valA);
        showReg("load value", 5'd13);
        checkValid = 1'b0;
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/rvIsaPkg.sv
source/dpCtrlPkg.sv
source/pcControl.sv
source/registerFile.sv
source/alu.sv
source/immExtend.sv
source/riscvDataPath.sv
tb/tbRiscvDataPath.sv
